// ==== cfg_pkg.sv ====
// ######################################
// Shared definitions for the sequencer
// Address map, region lengths, AXI4-Lite
// channel structs, mode and control words
// ######################################

`default_nettype none

package cfg_pkg;

    localparam int ADDR_W = 13;
    localparam int DATA_W = 32;
    localparam int N_ARGS = 20;

    // Accelerator register map
    localparam logic [ADDR_W-1:0] CONTROL_OFFSET     = 13'h000;
    localparam logic [ADDR_W-1:0] INTR_EN_OFFSET     = 13'h004;
    localparam logic [ADDR_W-1:0] INTR_STATUS_OFFSET = 13'h00C;
    localparam logic [ADDR_W-1:0] MAIN_BASE          = 13'h010;
    localparam logic [ADDR_W-1:0] ACT_BASE           = 13'h100;
    localparam logic [ADDR_W-1:0] WEI_BASE           = 13'h200;
    localparam logic [ADDR_W-1:0] OUT_BASE           = 13'h300;

    // Words per region
    localparam int MAIN_LEN = 2;
    localparam int ACT_LEN  = 9;
    localparam int WEI_LEN  = 4;
    localparam int OUT_LEN  = 5;
    localparam int INTR_LEN = 2;

    // Arguments plus the two interrupt enables
    localparam int N_CFG_WRITES = N_ARGS + INTR_LEN;

    typedef enum logic [2:0] {
        REG_MAIN,
        REG_ACT,
        REG_WEI,
        REG_OUT,
        REG_INTR
    } region_e;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
    } wr_cmd_t;

    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] addr;
    } axil_aw_t;

    typedef struct packed {
        logic                valid;
        logic [DATA_W-1:0]   data;
        logic [DATA_W/8-1:0] strb;
    } axil_w_t;

    typedef struct packed {
        logic       valid;
        logic [1:0] resp;
    } axil_b_t;

    typedef struct packed {
        logic [8:0]  rsv_hi;
        logic        config_only;
        logic        keep_c;
        logic        keep_b;
        logic        keep_a;
        logic [18:0] rsv_lo;
    } mode_word_t;

    typedef struct packed {
        logic [11:0] rsv_hi;
        logic        keep_c;
        logic        keep_b;
        logic        keep_a;
        logic        buffer_swap;
        logic [13:0] rsv_mid;
        logic        enable;
        logic        start;
    } ctrl_fields_t;

    typedef union packed {
        logic [DATA_W-1:0] raw;
        ctrl_fields_t      f;
    } ctrl_word_u;

endpackage

`default_nettype wire

// ==== cfg_cmd_sequencer.sv ====
// ######################################
// Run FSM of the configuration sequencer
// Snapshots a run, emits the ordered write
// commands, waits on drain and interrupt
// ######################################

`default_nettype none

module cfg_cmd_sequencer #(
    parameter int N_ARGS = 20
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 run_start,
    input  cfg_pkg::mode_word_t                  mode,
    input  logic [N_ARGS-1:0][cfg_pkg::DATA_W-1:0] args,
    input  logic                                 accel_irq,
    input  logic                                 cmd_ready,
    input  logic                                 drained,
    output cfg_pkg::wr_cmd_t                     cmd,
    output logic                                 cmd_valid,
    output logic                                 run_done,
    output logic                                 irq_fwd
);

    import cfg_pkg::*;

    localparam int ARG_IDX_W = $clog2(N_ARGS + 1);

    typedef enum logic [2:0] {
        S_IDLE,
        S_ARGS,
        S_SYNC,
        S_CTRL,
        S_CTRL_WAIT,
        S_IRQ,
        S_CLR,
        S_CLR_WAIT
    } state_e;

    state_e                         state_q;
    region_e                        region_q;
    logic [ADDR_W-1:0]              addr_q;
    logic [3:0]                     count_q;
    logic [ARG_IDX_W-1:0]           arg_idx_q;
    logic [1:0]                     issuer_idle_q;
    mode_word_t                     mode_q;
    logic [N_ARGS-1:0][DATA_W-1:0]  args_q;
    ctrl_word_u                     ctrl;
    logic                           cmd_fire;
    logic                           drain_ok;

    assign cmd_valid = (state_q == S_ARGS) || (state_q == S_CTRL) || (state_q == S_CLR);
    assign cmd_fire  = cmd_valid && cmd_ready;
    assign irq_fwd   = (state_q == S_IDLE) && accel_irq;

    // The issuer counts a write only a cycle after it leaves, so drained
    // is trusted once the issuer has sat empty for two cycles
    assign drain_ok = drained && (&issuer_idle_q);

    always_comb begin
        ctrl               = '0;
        ctrl.f.start       = ~mode_q.config_only;
        ctrl.f.enable      = 1'b1;
        ctrl.f.buffer_swap = 1'b1;
        ctrl.f.keep_a      = mode_q.keep_a;
        ctrl.f.keep_b      = mode_q.keep_b;
        ctrl.f.keep_c      = mode_q.keep_c && !mode_q.config_only;

        cmd.addr = addr_q;
        case (state_q)
            S_ARGS:  cmd.data = (region_q == REG_INTR) ? DATA_W'(1) : args_q[arg_idx_q];
            S_CTRL:  cmd.data = ctrl.raw;
            default: cmd.data = DATA_W'(1);
        endcase
    end

    // Run snapshot
    always_ff @(posedge clk) begin
        if (state_q == S_IDLE && run_start) begin
            mode_q <= mode;
            args_q <= args;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q       <= S_IDLE;
            region_q      <= REG_MAIN;
            addr_q        <= MAIN_BASE;
            count_q       <= '0;
            arg_idx_q     <= '0;
            issuer_idle_q <= '0;
            run_done      <= 1'b0;
        end else begin
            run_done      <= 1'b0;
            issuer_idle_q <= {issuer_idle_q[0], cmd_ready && !cmd_valid};

            case (state_q)
                S_IDLE: begin
                    region_q  <= REG_MAIN;
                    addr_q    <= MAIN_BASE;
                    count_q   <= 4'(MAIN_LEN - 1);
                    arg_idx_q <= '0;
                    if (run_start) begin
                        state_q <= S_ARGS;
                    end
                end

                S_ARGS: begin
                    if (cmd_fire) begin
                        if (region_q != REG_INTR) begin
                            arg_idx_q <= arg_idx_q + 1'b1;
                        end
                        if (count_q == '0) begin
                            case (region_q)
                                REG_MAIN: begin
                                    region_q <= REG_ACT;
                                    addr_q   <= ACT_BASE;
                                    count_q  <= 4'(ACT_LEN - 1);
                                end
                                REG_ACT: begin
                                    region_q <= REG_WEI;
                                    addr_q   <= WEI_BASE;
                                    count_q  <= 4'(WEI_LEN - 1);
                                end
                                REG_WEI: begin
                                    region_q <= REG_OUT;
                                    addr_q   <= OUT_BASE;
                                    count_q  <= 4'(OUT_LEN - 1);
                                end
                                REG_OUT: begin
                                    region_q <= REG_INTR;
                                    addr_q   <= INTR_EN_OFFSET;
                                    count_q  <= 4'(INTR_LEN - 1);
                                end
                                default: begin
                                    addr_q  <= CONTROL_OFFSET;
                                    state_q <= S_SYNC;
                                end
                            endcase
                        end else begin
                            addr_q  <= addr_q + ADDR_W'(4);
                            count_q <= count_q - 1'b1;
                        end
                    end
                end

                // All configuration responses back before the control word
                S_SYNC: begin
                    if (drain_ok) begin
                        state_q <= S_CTRL;
                    end
                end

                S_CTRL: begin
                    if (cmd_fire) begin
                        state_q <= S_CTRL_WAIT;
                    end
                end

                S_CTRL_WAIT: begin
                    if (drain_ok) begin
                        if (mode_q.config_only) begin
                            run_done <= 1'b1;
                            state_q  <= S_IDLE;
                        end else begin
                            addr_q  <= INTR_STATUS_OFFSET;
                            state_q <= S_IRQ;
                        end
                    end
                end

                S_IRQ: begin
                    if (accel_irq) begin
                        state_q <= S_CLR;
                    end
                end

                S_CLR: begin
                    if (cmd_fire) begin
                        state_q <= S_CLR_WAIT;
                    end
                end

                S_CLR_WAIT: begin
                    if (drain_ok) begin
                        run_done <= 1'b1;
                        state_q  <= S_IDLE;
                    end
                end

                default: state_q <= S_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== axil_write_issuer.sv ====
// ######################################
// One-entry AXI4-Lite write stage
// Drives AW and W independently
// ######################################

`default_nettype none

module axil_write_issuer (
    input  logic              clk,
    input  logic              rst,
    input  cfg_pkg::wr_cmd_t  cmd,
    input  logic              cmd_valid,
    input  logic              aw_ready,
    input  logic              w_ready,
    output logic              cmd_ready,
    output cfg_pkg::axil_aw_t aw,
    output cfg_pkg::axil_w_t  w,
    output logic              issued
);

    import cfg_pkg::*;

    wr_cmd_t cmd_q;
    logic    full_q;
    logic    aw_done_q;
    logic    w_done_q;
    logic    both_done;
    logic    load;

    // Each channel either finished earlier or is accepted now
    assign both_done = full_q && (aw_done_q || aw_ready) && (w_done_q || w_ready);
    assign cmd_ready = !full_q || both_done;
    assign load      = cmd_valid && cmd_ready;

    always_comb begin
        aw.valid = full_q && !aw_done_q;
        aw.addr  = cmd_q.addr;
        w.valid  = full_q && !w_done_q;
        w.data   = cmd_q.data;
        w.strb   = {(DATA_W/8){1'b1}};
    end

    always_ff @(posedge clk) begin
        if (load) begin
            cmd_q <= cmd;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            full_q    <= 1'b0;
            aw_done_q <= 1'b0;
            w_done_q  <= 1'b0;
            issued    <= 1'b0;
        end else begin
            issued <= both_done;
            if (load) begin
                full_q    <= 1'b1;
                aw_done_q <= 1'b0;
                w_done_q  <= 1'b0;
            end else if (both_done) begin
                full_q    <= 1'b0;
                aw_done_q <= 1'b0;
                w_done_q  <= 1'b0;
            end else begin
                aw_done_q <= aw_done_q || aw.valid && aw_ready;
                w_done_q  <= w_done_q || w.valid && w_ready;
            end
        end
    end

endmodule

`default_nettype wire

// ==== wresp_tracker.sv ====
// ######################################
// Outstanding write counter on channel B
// ######################################

`default_nettype none

module wresp_tracker #(
    parameter int MAX_OUTSTANDING = 4
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             issued,
    input  cfg_pkg::axil_b_t b,
    output logic             b_ready,
    output logic             drained
);

    localparam int CNT_W = $clog2(MAX_OUTSTANDING + 1);

    logic [CNT_W-1:0] count_q;
    logic             b_accept;

    assign b_ready  = (count_q != '0);
    assign drained  = (count_q == '0);
    assign b_accept = b.valid && b_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            count_q <= '0;
        end else begin
            // Issue and response together cancel out
            case ({issued, b_accept})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== cfg_sequencer_top.sv ====
// ######################################
// Configuration sequencer top level
// Command FSM, write issuer, B tracker
// ######################################

`default_nettype none

module cfg_sequencer_top #(
    parameter int N_ARGS          = cfg_pkg::N_ARGS,
    // A whole configuration burst may be in flight at once
    parameter int MAX_OUTSTANDING = cfg_pkg::N_CFG_WRITES
) (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   run_start,
    input  cfg_pkg::mode_word_t                    mode,
    input  logic [N_ARGS-1:0][cfg_pkg::DATA_W-1:0] args,
    input  logic                                   accel_irq,
    input  logic                                   aw_ready,
    input  logic                                   w_ready,
    input  cfg_pkg::axil_b_t                       b,
    output cfg_pkg::axil_aw_t                      aw,
    output cfg_pkg::axil_w_t                       w,
    output logic                                   b_ready,
    output logic                                   run_done,
    output logic                                   irq_fwd
);

    import cfg_pkg::*;

    wr_cmd_t cmd;
    logic    cmd_valid;
    logic    cmd_ready;
    logic    issued;
    logic    drained;

    cfg_cmd_sequencer #(
        .N_ARGS (N_ARGS)
    ) u_sequencer (
        .clk       (clk),
        .rst       (rst),
        .run_start (run_start),
        .mode      (mode),
        .args      (args),
        .accel_irq (accel_irq),
        .cmd_ready (cmd_ready),
        .drained   (drained),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .run_done  (run_done),
        .irq_fwd   (irq_fwd)
    );

    axil_write_issuer u_issuer (
        .clk       (clk),
        .rst       (rst),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .aw_ready  (aw_ready),
        .w_ready   (w_ready),
        .cmd_ready (cmd_ready),
        .aw        (aw),
        .w         (w),
        .issued    (issued)
    );

    wresp_tracker #(
        .MAX_OUTSTANDING (MAX_OUTSTANDING)
    ) u_tracker (
        .clk     (clk),
        .rst     (rst),
        .issued  (issued),
        .b       (b),
        .b_ready (b_ready),
        .drained (drained)
    );

endmodule

`default_nettype wire

// ==== tb_clk_gen.sv ====
// ######################################
// Testbench clock and reset generator
// ######################################

`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD     = 8,
    parameter int RST_CYCLES = 16
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

// ==== tb_cfg_sequencer.sv ====
// ########################################
// Testbench for the configuration sequencer
// Trace-driven runs, AXI4-Lite slave model
// with random stalls, write and done checks
// ########################################

`default_nettype none

module tb_cfg_sequencer;

    import cfg_pkg::*;

    localparam int          N_RUN_ARGS  = 20;
    localparam int          TRACE_WORDS = 256;
    localparam int          MAX_WRITES  = 32;
    localparam int          RST_TIMEOUT = 100;
    localparam int          RUN_TIMEOUT = 4000;
    localparam logic [12:0] CTRL_ADDR   = 13'h000;
    localparam logic [12:0] CLR_ADDR    = 13'h00c;

    logic                        clk;
    logic                        rst;
    logic                        run_start;
    mode_word_t                  mode;
    logic [N_RUN_ARGS-1:0][31:0] args;
    logic                        accel_irq = 1'b0;
    logic                        aw_ready  = 1'b0;
    logic                        w_ready   = 1'b0;
    axil_b_t                     b         = '0;
    axil_aw_t                    aw;
    axil_w_t                     w;
    logic                        b_ready;
    logic                        run_done;
    logic                        irq_fwd;

    // Trace and the expected writes of the current run
    logic [31:0] trace_mem [0:TRACE_WORDS-1];
    logic [12:0] exp_addr [0:MAX_WRITES-1];
    logic [31:0] exp_data [0:MAX_WRITES-1];
    int          exp_count = 0;
    int          irq_delay = 0;
    logic        cfg_only  = 1'b0;

    // Slave model and monitor state
    integer      seed = 31664;
    logic [12:0] aw_q [$];
    logic [31:0] w_q [$];
    int          resp_q [$];
    int          wr_idx        = 0;
    int          completed     = 0;
    int          returned      = 0;
    int          irq_cnt       = 0;
    logic        b_fire        = 1'b0;
    logic        aw_hold       = 1'b0;
    logic        w_hold        = 1'b0;
    logic        done_prev     = 1'b0;
    logic        done_seen     = 1'b0;
    logic        in_run        = 1'b0;
    logic        ctrl_aw_seen  = 1'b0;
    logic        irq_armed     = 1'b0;
    logic        irq_clear_req = 1'b0;
    logic        run_irq       = 1'b0;
    logic        idle_irq_req  = 1'b0;
    axil_aw_t    aw_last;
    axil_w_t     w_last;
    logic [12:0] pair_addr;
    logic [31:0] pair_data;

    tb_clk_gen #(
        .PERIOD     (8),
        .RST_CYCLES (16)
    ) u_clk_gen (
        .clk (clk),
        .rst (rst)
    );

    cfg_sequencer_top #(
        .N_ARGS (N_RUN_ARGS)
    ) u_cfg_sequencer_top (
        .clk       (clk),
        .rst       (rst),
        .run_start (run_start),
        .mode      (mode),
        .args      (args),
        .accel_irq (accel_irq),
        .aw_ready  (aw_ready),
        .w_ready   (w_ready),
        .b         (b),
        .aw        (aw),
        .w         (w),
        .b_ready   (b_ready),
        .run_done  (run_done),
        .irq_fwd   (irq_fwd)
    );

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Error: %s got 0x%08h expected 0x%08h", name, got, exp);
            $display("Simulation finished: FAIL");
            $fatal(1);
        end
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    // One completed AW and W pair against the trace
    task automatic record_write(input logic [12:0] addr, input logic [31:0] data);
        if (wr_idx >= exp_count) begin
            report_failure($sformatf("Unexpected write to address 0x%03h after the last one",
                                     addr));
        end else begin
            check_value($sformatf("write %0d addr", wr_idx), addr, exp_addr[wr_idx]);
            check_value($sformatf("write %0d data", wr_idx), data, exp_data[wr_idx]);
            wr_idx++;
            completed++;
            resp_q.push_back($random(seed) & 3);
            if (addr == CTRL_ADDR && !cfg_only) begin
                irq_cnt   = irq_delay;
                irq_armed = 1'b1;
            end
            if (addr == CLR_ADDR) begin
                irq_clear_req = 1'b1;
            end
        end
    endtask

    // Monitor, samples at the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            if (in_run) begin
                check_value("irq_fwd", irq_fwd, 1'b0);
            end else begin
                check_value("irq_fwd", irq_fwd, accel_irq);
            end
            if (run_done && (done_prev || !in_run)) begin
                report_failure("run_done pulsed outside a run or for more than one cycle");
            end
            done_prev = run_done;
            if (run_done) begin
                done_seen = 1'b1;
            end

            // A stalled channel keeps valid and content
            if (aw_hold) begin
                check_value("aw.valid", aw.valid, 1'b1);
                check_value("aw.addr", aw.addr, aw_last.addr);
            end
            if (w_hold) begin
                check_value("w.valid", w.valid, 1'b1);
                check_value("w.data", w.data, w_last.data);
            end
            aw_hold = aw.valid && !aw_ready;
            w_hold  = w.valid && !w_ready;
            aw_last = aw;
            w_last  = w;

            if (aw.valid && aw.addr == CTRL_ADDR && !ctrl_aw_seen) begin
                ctrl_aw_seen = 1'b1;
                check_value("outstanding at control write", completed - returned, 0);
            end
            if (aw.valid && aw.addr == CLR_ADDR) begin
                check_value("accel_irq at clear write", accel_irq, 1'b1);
            end

            if (aw.valid && aw_ready) begin
                aw_q.push_back(aw.addr);
            end
            if (w.valid && w_ready) begin
                check_value("w.strb", w.strb, 4'hf);
                w_q.push_back(w.data);
            end
            while (aw_q.size() > 0 && w_q.size() > 0) begin
                pair_addr = aw_q.pop_front();
                pair_data = w_q.pop_front();
                record_write(pair_addr, pair_data);
            end

            b_fire = b.valid && b_ready;
            if (b_fire) begin
                returned++;
            end
        end
    end

    // Slave drivers, update on the rising edge
    always @(posedge clk) begin
        if (rst) begin
            aw_ready  <= 1'b0;
            w_ready   <= 1'b0;
            b         <= '0;
            accel_irq <= 1'b0;
        end else begin
            aw_ready <= ($random(seed) & 3) != 0;
            w_ready  <= ($random(seed) & 3) != 0;

            // One response at a time, each after its own delay
            if (b.valid) begin
                if (b_fire) begin
                    b.valid <= 1'b0;
                end
            end else if (resp_q.size() > 0) begin
                if (resp_q[0] == 0) begin
                    b.valid <= 1'b1;
                    b.resp  <= 2'b00;
                    void'(resp_q.pop_front());
                end else begin
                    resp_q[0] = resp_q[0] - 1;
                end
            end

            if (irq_armed) begin
                if (irq_cnt == 0) begin
                    run_irq   = 1'b1;
                    irq_armed = 1'b0;
                end else begin
                    irq_cnt--;
                end
            end
            if (irq_clear_req) begin
                run_irq       = 1'b0;
                irq_clear_req = 1'b0;
            end
            accel_irq <= run_irq || idle_irq_req;
        end
    end

    initial begin : main
        int                          ptr;
        int                          n_runs;
        int                          cycles;
        mode_word_t                  run_mode;
        logic [N_RUN_ARGS-1:0][31:0] run_args;

        run_start = 1'b0;
        mode      = '0;
        args      = '0;
        $readmemh("cfg_trace.txt", trace_mem);

        cycles = 0;
        @(negedge clk);
        while (rst && cycles < RST_TIMEOUT) begin
            cycles++;
            @(negedge clk);
        end
        if (rst) begin
            report_failure("Timeout waiting for reset to be released");
        end
        check_value("aw.valid", aw.valid, 1'b0);
        check_value("w.valid", w.valid, 1'b0);
        check_value("b_ready", b_ready, 1'b0);
        check_value("run_done", run_done, 1'b0);

        n_runs = trace_mem[0];
        ptr    = 1;
        for (int r = 0; r < n_runs; r++) begin
            run_mode  = trace_mem[ptr];
            irq_delay = trace_mem[ptr + 1];
            exp_count = trace_mem[ptr + 2];
            cfg_only  = run_mode.config_only;
            ptr += 3;
            for (int i = 0; i < N_RUN_ARGS; i++) begin
                run_args[i] = trace_mem[ptr + i];
            end
            ptr += N_RUN_ARGS;
            for (int i = 0; i < exp_count; i++) begin
                exp_addr[i] = trace_mem[ptr + 2 * i][12:0];
                exp_data[i] = trace_mem[ptr + 2 * i + 1];
            end
            ptr += 2 * exp_count;

            // Interrupt pulse while idle goes straight to irq_fwd
            @(posedge clk);
            idle_irq_req <= 1'b1;
            repeat (3) @(posedge clk);
            idle_irq_req <= 1'b0;
            repeat (3) @(posedge clk);

            wr_idx       = 0;
            ctrl_aw_seen = 1'b0;
            done_seen    = 1'b0;
            in_run       = 1'b1;
            run_start <= 1'b1;
            mode      <= run_mode;
            args      <= run_args;
            @(posedge clk);
            run_start <= 1'b0;
            // Inputs change after the start so only the snapshot can be used
            mode      <= ~run_mode;
            args      <= ~run_args;

            cycles = 0;
            while (!done_seen && cycles < RUN_TIMEOUT) begin
                @(posedge clk);
                cycles++;
            end
            if (!done_seen) begin
                report_failure($sformatf("Timeout waiting for run_done in run %0d", r));
            end
            in_run = 1'b0;
            check_value("write count", wr_idx, exp_count);
            check_value("outstanding at run_done", completed - returned, 0);
        end

        repeat (4) @(posedge clk);
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== cfg_trace.txt ====
// Hex words. First the run count, then per run: mode, irq delay, write count,
// twenty argument words, and the expected writes as address and data pairs
3

// Run 0, normal with keep_a and keep_c
00281234 00000005 00000018
a5a50000 a5a50001 a5a50002 a5a50003 a5a50004 a5a50005 a5a50006 a5a50007 a5a50008 a5a50009
a5a5000a a5a5000b a5a5000c a5a5000d a5a5000e a5a5000f a5a50010 a5a50011 a5a50012 a5a50013
0010 a5a50000 0014 a5a50001 0100 a5a50002 0104 a5a50003
0108 a5a50004 010c a5a50005 0110 a5a50006 0114 a5a50007
0118 a5a50008 011c a5a50009 0120 a5a5000a 0200 a5a5000b
0204 a5a5000c 0208 a5a5000d 020c a5a5000e 0300 a5a5000f
0304 a5a50010 0308 a5a50011 030c a5a50012 0310 a5a50013
0004 00000001 0008 00000001 0000 000b0003 000c 00000001

// Run 1, configuration only with all keep bits
00780000 00000000 00000017
5a5a0000 5a5a0001 5a5a0002 5a5a0003 5a5a0004 5a5a0005 5a5a0006 5a5a0007 5a5a0008 5a5a0009
5a5a000a 5a5a000b 5a5a000c 5a5a000d 5a5a000e 5a5a000f 5a5a0010 5a5a0011 5a5a0012 5a5a0013
0010 5a5a0000 0014 5a5a0001 0100 5a5a0002 0104 5a5a0003
0108 5a5a0004 010c 5a5a0005 0110 5a5a0006 0114 5a5a0007
0118 5a5a0008 011c 5a5a0009 0120 5a5a000a 0200 5a5a000b
0204 5a5a000c 0208 5a5a000d 020c 5a5a000e 0300 5a5a000f
0304 5a5a0010 0308 5a5a0011 030c 5a5a0012 0310 5a5a0013
0004 00000001 0008 00000001 0000 00070002

// Run 2, normal with keep_b and reserved high bits set
ff900000 0000000c 00000018
0f0f0000 0f0f0001 0f0f0002 0f0f0003 0f0f0004 0f0f0005 0f0f0006 0f0f0007 0f0f0008 0f0f0009
0f0f000a 0f0f000b 0f0f000c 0f0f000d 0f0f000e 0f0f000f 0f0f0010 0f0f0011 0f0f0012 0f0f0013
0010 0f0f0000 0014 0f0f0001 0100 0f0f0002 0104 0f0f0003
0108 0f0f0004 010c 0f0f0005 0110 0f0f0006 0114 0f0f0007
0118 0f0f0008 011c 0f0f0009 0120 0f0f000a 0200 0f0f000b
0204 0f0f000c 0208 0f0f000d 020c 0f0f000e 0300 0f0f000f
0304 0f0f0010 0308 0f0f0011 030c 0f0f0012 0310 0f0f0013
0004 00000001 0008 00000001 0000 00050003 000c 00000001

// ==== files.f ====
cfg_pkg.sv
cfg_cmd_sequencer.sv
axil_write_issuer.sv
wresp_tracker.sv
cfg_sequencer_top.sv
tb_clk_gen.sv
tb_cfg_sequencer.sv

// ==== Bender.yml ====
package:
  name: cfg_sequencer

sources:
  - files:
      - cfg_pkg.sv
      - cfg_cmd_sequencer.sv
      - axil_write_issuer.sv
      - wresp_tracker.sv
      - cfg_sequencer_top.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_cfg_sequencer.sv
